/* hdl/alu_pkg.sv */
// alu peripheral definitions: opcodes, register map, command word, flags and axi4-lite bundles.

package alu_pkg;

	// ********************************************************************
	// opcodes and register map
	// ********************************************************************

	// 4-bit opcode, codes 9 to 15 are rejected by the register bank.
	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_AND = 4'd2,
		OP_OR  = 4'd3,
		OP_XOR = 4'd4,
		OP_SHL = 4'd5,
		OP_SHR = 4'd6,
		OP_SAR = 4'd7,
		OP_ROL = 4'd8
	} alu_op_e;

	// byte offsets, the slave looks at bits 4:2 only.
	localparam logic [31:0] REG_A      = 32'h0000_0000;
	localparam logic [31:0] REG_B      = 32'h0000_0004;
	localparam logic [31:0] REG_CMD    = 32'h0000_0008;
	localparam logic [31:0] REG_RESULT = 32'h0000_000C;
	localparam logic [31:0] REG_FLAGS  = 32'h0000_0010;

	// axi response codes.
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// ********************************************************************
	// command word, one word seen two ways
	// ********************************************************************

	// arithmetic view, carry-in sits just above the opcode.
	typedef struct packed {
		logic [19:0] rsvd;
		logic [6:0]  unused;
		logic        ci;
		alu_op_e     op;
	} alu_arith_cmd_t;

	// shift view, same bits read as a 5-bit amount.
	typedef struct packed {
		logic [19:0] rsvd;
		logic [2:0]  unused;
		logic [4:0]  amount;
		alu_op_e     op;
	} alu_shift_cmd_t;

	typedef union packed {
		alu_arith_cmd_t arith;
		alu_shift_cmd_t shift;
	} alu_cmd_u;

	// flags, carry lands in bit 0 of the readback word.
	typedef struct packed {
		logic negative;
		logic zero;
		logic overflow;
		logic carry;
	} alu_flags_t;

	// ********************************************************************
	// axi4-lite bundles
	// ********************************************************************

	// driven by the master.
	typedef struct packed {
		logic        awvalid;
		logic [31:0] awaddr;
		logic        wvalid;
		logic [31:0] wdata;
		logic        bready;
		logic        arvalid;
		logic [31:0] araddr;
		logic        rready;
	} axil_req_t;

	// driven by the slave.
	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

endpackage

/* hdl/alu_addsub.sv */
// adder/subtracter with carry-in, carry-out and signed overflow.
`timescale 1ns/1ps

module alu_addsub #(
	parameter int WIDTH = 32
) (
	input  logic             sub,
	input  logic             ci,
	input  logic [WIDTH-1:0] a,
	input  logic [WIDTH-1:0] b,
	output logic [WIDTH-1:0] sum,
	output logic             co,
	output logic             v
);

	// second operand after the optional inversion.
	logic [WIDTH-1:0] b_op;
	// one bit wider than the operands, top bit is the carry.
	logic [WIDTH:0]   total;

	// subtract is a + ~b + ci.
	// so ci = 1 means no borrow in, and co = 1 means no borrow out.
	assign b_op = sub ? ~b : b;

	// single add over WIDTH+1 bits.
	assign total = {1'b0, a} + {1'b0, b_op} + {{WIDTH{1'b0}}, ci};

	assign sum = total[WIDTH-1:0];
	assign co  = total[WIDTH];

	// overflow when both addends share a sign and the sum has the other one.
	// b_op already carries the inverted sign for subtract.
	assign v = (a[WIDTH-1] == b_op[WIDTH-1]) && (sum[WIDTH-1] != a[WIDTH-1]);

endmodule

/* hdl/alu_logic.sv */
// bitwise unit for and, or and xor.
`timescale 1ns/1ps

module alu_logic import alu_pkg::*; #(
	parameter int WIDTH = 32
) (
	input  alu_op_e          op,
	input  logic [WIDTH-1:0] a,
	input  logic [WIDTH-1:0] b,
	output logic [WIDTH-1:0] y
);

	// one result per opcode.
	// other opcodes give zero, the register bank picks another unit then.
	always_comb begin
		case (op)
			OP_AND:  y = a & b;
			OP_OR:   y = a | b;
			OP_XOR:  y = a ^ b;
			default: y = '0;
		endcase
	end

endmodule

/* hdl/alu_shift.sv */
// barrel shifter for shl, shr, sar and rol with a shifted-out carry.
`timescale 1ns/1ps

module alu_shift import alu_pkg::*; #(
	parameter int WIDTH = 32
) (
	input  alu_op_e          op,
	input  logic [WIDTH-1:0] a,
	input  logic [4:0]       amount,
	output logic [WIDTH-1:0] y,
	output logic             co
);

	// number of stages, one per amount bit.
	localparam int SW = $clog2(WIDTH);

	logic [SW-1:0]    amt;
	logic             right;
	logic             rot;
	logic             fill;
	logic [WIDTH-1:0] a_rev;
	logic [WIDTH-1:0] src;
	logic [WIDTH-1:0] shifted;
	logic [WIDTH-1:0] shifted_rev;
	// bit WIDTH of each stage holds the last bit pushed out.
	logic [WIDTH:0]   stage [SW+1];

	// amount is taken modulo the datapath width.
	assign amt   = SW'(amount % WIDTH);
	assign right = (op == OP_SHR) || (op == OP_SAR);
	assign rot   = (op == OP_ROL);
	// sar fills with the sign bit, everything else with zero.
	assign fill  = (op == OP_SAR) && a[WIDTH-1];

	// right shifts run as left shifts on the bit-reversed word.
	for (genvar j = 0; j < WIDTH; j++) begin : g_rev
		assign a_rev[j]       = a[WIDTH-1-j];
		assign shifted_rev[j] = shifted[WIDTH-1-j];
	end

	assign src      = right ? a_rev : a;
	assign stage[0] = {1'b0, src};

	// ********************************************************************
	// log2 stages, stage i moves by 2**i
	// ********************************************************************
	for (genvar i = 0; i < SW; i++) begin : g_stage
		localparam int S = 1 << i;
		logic [WIDTH-1:0] x;

		assign x = stage[i][WIDTH-1:0];
		// x[WIDTH-S] is the last bit to leave the top at this stage.
		assign stage[i+1] = !amt[i] ? stage[i] :
			rot ? {x[WIDTH-S], x[WIDTH-1-S:0], x[WIDTH-1:WIDTH-S]} :
			{x[WIDTH-S], x[WIDTH-1-S:0], {S{fill}}};
	end

	assign shifted = stage[SW][WIDTH-1:0];
	assign y       = right ? shifted_rev : shifted;

	// rotate reports the new lsb; a zero amount leaves the carry at zero.
	assign co = rot ? ((amt != '0) && shifted[0]) : stage[SW][WIDTH];

endmodule

/* hdl/alu_ctrl.sv */
// alu register bank: axi4-lite slave, operand and command registers, result and flag capture.
`timescale 1ns/1ps

module alu_ctrl import alu_pkg::*; #(
	parameter int WIDTH = 32
) (
	input  logic             clk,
	input  logic             rst_n,
	input  axil_req_t        req,
	output axil_rsp_t        rsp,
	output logic [WIDTH-1:0] a,
	output logic [WIDTH-1:0] b,
	output alu_cmd_u         cmd,
	input  logic [WIDTH-1:0] add_sum,
	input  logic             add_co,
	input  logic             add_v,
	input  logic [WIDTH-1:0] logic_y,
	input  logic [WIDTH-1:0] shift_y,
	input  logic             shift_co
);

	// register bank.
	logic [WIDTH-1:0] a_q;
	logic [WIDTH-1:0] b_q;
	alu_cmd_u         cmd_q;
	logic [WIDTH-1:0] result_q;
	alu_flags_t       flags_q;

	// response channel state.
	logic             bvalid_q;
	logic [1:0]       bresp_q;
	logic             rvalid_q;
	logic [31:0]      rdata_q;
	logic [1:0]       rresp_q;

	// decode.
	logic             wr_go;
	logic [2:0]       wr_idx;
	logic             wr_ok;
	logic             cmd_wr;
	logic             rd_go;
	logic [2:0]       rd_idx;
	logic             rd_ok;
	logic [31:0]      rd_data;
	logic [WIDTH-1:0] res_sel;
	alu_flags_t       flags_sel;

	function automatic logic op_legal(input logic [3:0] code);
		return code inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
			OP_SHL, OP_SHR, OP_SAR, OP_ROL};
	endfunction

	// ********************************************************************
	// write channel
	// ********************************************************************

	// address and data are taken together, only with no response pending.
	assign wr_go  = req.awvalid && req.wvalid && !bvalid_q;
	assign wr_idx = req.awaddr[4:2];

	// result and flags are read-only.
	always_comb begin
		case (wr_idx)
			REG_A[4:2], REG_B[4:2]: wr_ok = 1'b1;
			REG_CMD[4:2]:           wr_ok = op_legal(req.wdata[3:0]);
			default:                wr_ok = 1'b0;
		endcase
	end

	assign cmd_wr = wr_go && wr_ok && (wr_idx == REG_CMD[4:2]);

	// the datapath sees the incoming command in its write cycle.
	// so the result is ready on the accepting edge.
	assign cmd = cmd_wr ? alu_cmd_u'(req.wdata) : cmd_q;
	assign a   = a_q;
	assign b   = b_q;

	// pick the unit and its flags by opcode.
	always_comb begin
		res_sel   = '0;
		flags_sel = '0;
		case (cmd.arith.op)
			OP_ADD, OP_SUB: begin
				res_sel            = add_sum;
				flags_sel.carry    = add_co;
				flags_sel.overflow = add_v;
			end
			OP_AND, OP_OR, OP_XOR: begin
				res_sel = logic_y;
			end
			OP_SHL, OP_SHR, OP_SAR, OP_ROL: begin
				res_sel         = shift_y;
				flags_sel.carry = shift_co;
			end
			default: res_sel = '0;
		endcase
		flags_sel.zero     = (res_sel == '0);
		flags_sel.negative = res_sel[WIDTH-1];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			a_q      <= '0;
			b_q      <= '0;
			cmd_q    <= '0;
			result_q <= '0;
			flags_q  <= '0;
			bvalid_q <= 1'b0;
		end else begin
			// bvalid holds until the master takes it.
			if (wr_go) begin
				bvalid_q <= 1'b1;
			end else if (req.bready) begin
				bvalid_q <= 1'b0;
			end
			// a rejected write touches nothing.
			if (wr_go && wr_ok) begin
				case (wr_idx)
					REG_A[4:2]: a_q <= req.wdata[WIDTH-1:0];
					REG_B[4:2]: b_q <= req.wdata[WIDTH-1:0];
					REG_CMD[4:2]: begin
						cmd_q    <= cmd;
						result_q <= res_sel;
						flags_q  <= flags_sel;
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_go) begin
			bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// ********************************************************************
	// read channel
	// ********************************************************************

	assign rd_go  = req.arvalid && !rvalid_q;
	assign rd_idx = req.araddr[4:2];

	// narrow registers read back zero-extended.
	always_comb begin
		rd_ok = 1'b1;
		case (rd_idx)
			REG_A[4:2]:      rd_data = 32'(a_q);
			REG_B[4:2]:      rd_data = 32'(b_q);
			REG_CMD[4:2]:    rd_data = cmd_q;
			REG_RESULT[4:2]: rd_data = 32'(result_q);
			REG_FLAGS[4:2]:  rd_data = 32'(flags_q);
			default: begin
				rd_ok   = 1'b0;
				rd_data = '0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rvalid_q <= 1'b0;
		end else if (rd_go) begin
			rvalid_q <= 1'b1;
		end else if (req.rready) begin
			rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_go) begin
			rdata_q <= rd_data;
			rresp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// slave side of the bus.
	always_comb begin
		rsp.awready = wr_go;
		rsp.wready  = wr_go;
		rsp.bvalid  = bvalid_q;
		rsp.bresp   = bresp_q;
		rsp.arready = rd_go;
		rsp.rvalid  = rvalid_q;
		rsp.rdata   = rdata_q;
		rsp.rresp   = rresp_q;
	end

endmodule

/* hdl/alu_unit.sv */
// alu peripheral top: register bank around the add/sub, logic and shift units.
`timescale 1ns/1ps

module alu_unit import alu_pkg::*; #(
	parameter int WIDTH = 32
) (
	input  logic      clk,
	input  logic      rst_n,
	input  axil_req_t req,
	output axil_rsp_t rsp
);

	// operands and command from the register bank.
	logic [WIDTH-1:0] a;
	logic [WIDTH-1:0] b;
	alu_cmd_u         cmd;

	// unit results back to the register bank.
	logic [WIDTH-1:0] add_sum;
	logic             add_co;
	logic             add_v;
	logic [WIDTH-1:0] logic_y;
	logic [WIDTH-1:0] shift_y;
	logic             shift_co;

	// ********************************************************************
	// register bank and bus slave
	// ********************************************************************
	alu_ctrl #(
		.WIDTH(WIDTH)
	) ctrl_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.req      (req),
		.rsp      (rsp),
		.a        (a),
		.b        (b),
		.cmd      (cmd),
		.add_sum  (add_sum),
		.add_co   (add_co),
		.add_v    (add_v),
		.logic_y  (logic_y),
		.shift_y  (shift_y),
		.shift_co (shift_co)
	);

	// ********************************************************************
	// datapath units, all combinational
	// ********************************************************************

	// arithmetic view of the command word.
	alu_addsub #(
		.WIDTH(WIDTH)
	) addsub_i (
		.sub (cmd.arith.op == OP_SUB),
		.ci  (cmd.arith.ci),
		.a   (a),
		.b   (b),
		.sum (add_sum),
		.co  (add_co),
		.v   (add_v)
	);

	alu_logic #(
		.WIDTH(WIDTH)
	) logic_i (
		.op (cmd.arith.op),
		.a  (a),
		.b  (b),
		.y  (logic_y)
	);

	// shift view of the same word.
	alu_shift #(
		.WIDTH(WIDTH)
	) shift_i (
		.op     (cmd.shift.op),
		.a      (a),
		.amount (cmd.shift.amount),
		.y      (shift_y),
		.co     (shift_co)
	);

endmodule

/* dv/alu_unit_chk.sv */
// axi4-lite handshake checker bound into the alu register bank.
`timescale 1ns/1ps

module alu_unit_chk import alu_pkg::*; (
	input logic      clk,
	input logic      rst_n,
	input axil_req_t req,
	input axil_rsp_t rsp
);

	// ********************************************************************
	// reset state
	// ********************************************************************

	// first edge after reset release sees an idle slave.
	a_idle_after_reset: assert property (
		@(posedge clk) $rose(rst_n) |->
			!rsp.awready && !rsp.wready && !rsp.arready && !rsp.bvalid && !rsp.rvalid
	) else $error("handshake outputs not idle after reset");

	// ********************************************************************
	// response channels
	// ********************************************************************

	// a write response waits for bready.
	a_bvalid_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		rsp.bvalid && !req.bready |=> rsp.bvalid
	) else $error("bvalid dropped before bready");

	// a read response waits for rready.
	a_rvalid_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		rsp.rvalid && !req.rready |=> rsp.rvalid
	) else $error("rvalid dropped before rready");

	// write accept to bvalid is one cycle.
	a_write_resp: assert property (
		@(posedge clk) disable iff (!rst_n)
		req.awvalid && rsp.awready |=> rsp.bvalid
	) else $error("bvalid missing one cycle after write accept");

	// read accept to rvalid is one cycle.
	a_read_resp: assert property (
		@(posedge clk) disable iff (!rst_n)
		req.arvalid && rsp.arready |=> rsp.rvalid
	) else $error("rvalid missing one cycle after read accept");

endmodule

bind alu_ctrl alu_unit_chk chk_i (
	.clk   (clk),
	.rst_n (rst_n),
	.req   (req),
	.rsp   (rsp)
);

/* dv/alu_unit_tb.sv */
// alu peripheral testbench driving random axi4-lite commands against a reference model.
`timescale 1ns/1ps

module alu_unit_tb import alu_pkg::*;;

	localparam logic [31:0] SEED = 32'h60c72c8d;
	// reset, random ops at five bus transfers each, error cases and back-pressure.
	localparam int N_TRANS        = 3100;
	localparam int TIMEOUT_CYCLES = 64 * N_TRANS;

	logic        clk;
	logic        rst_n;
	axil_req_t   req;
	axil_rsp_t   rsp;
	logic [31:0] lcg_state;
	// {flags, result} of the last legal command.
	logic [35:0] last_exp;
	int unsigned cycles = 0;

	alu_unit #(
		.WIDTH(32)
	) dut_i (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (req),
		.rsp   (rsp)
	);

	always #5 clk = ~clk;

	// hard stop for a stuck handshake.
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("Something failed");
			$fatal(1, "timeout");
		end
	end

	// ********************************************************************
	// random numbers and reference model
	// ********************************************************************

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// the upper lcg bits have longer periods than the low ones.
	function automatic int rand_below(input int n);
		return int'((next_rand() >> 16) % 32'(n));
	endfunction

	function automatic logic [31:0] rand_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = next_rand();
		lo = next_rand();
		return {hi[31:16], lo[31:16]};
	endfunction

	// sign and carry edges show up often.
	function automatic logic [31:0] pick_operand();
		case (rand_below(16))
			0:       return 32'h7FFF_FFFF;
			1:       return 32'h8000_0000;
			2:       return 32'hFFFF_FFFF;
			3:       return 32'h0000_0000;
			default: return rand_word();
		endcase
	endfunction

	// returns {negative, zero, overflow, carry, result}.
	function automatic logic [35:0] ref_model(input logic [31:0] a, input logic [31:0] b,
		input logic [31:0] cmd_word);
		logic [3:0]  op;
		logic        ci;
		logic [4:0]  sh;
		logic [32:0] wide;
		logic [31:0] y;
		logic        c;
		logic        v;
		op = cmd_word[3:0];
		ci = cmd_word[4];
		sh = cmd_word[8:4];
		y  = '0;
		c  = 1'b0;
		v  = 1'b0;
		case (op)
			4'd0: begin
				wide = {1'b0, a} + {1'b0, b} + 33'(ci);
				y    = wide[31:0];
				c    = wide[32];
				v    = (a[31] == b[31]) && (y[31] != a[31]);
			end
			4'd1: begin
				// borrow out shows up in bit 32 and carry is its inverse.
				wide = {1'b0, a} - {1'b0, b} - 33'(!ci);
				y    = wide[31:0];
				c    = !wide[32];
				v    = (a[31] != b[31]) && (y[31] != a[31]);
			end
			4'd2: y = a & b;
			4'd3: y = a | b;
			4'd4: y = a ^ b;
			4'd5: begin
				y = a << sh;
				if (sh != 0) c = a[32 - int'(sh)];
			end
			4'd6: begin
				y = a >> sh;
				if (sh != 0) c = a[int'(sh) - 1];
			end
			4'd7: begin
				y = $signed(a) >>> sh;
				if (sh != 0) c = a[int'(sh) - 1];
			end
			4'd8: begin
				y = (a << sh) | (a >> (6'd32 - sh));
				if (sh != 0) c = y[0];
			end
			default: ;
		endcase
		return {y[31], (y == 32'd0), v, c, y};
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			$display("Something failed");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	// ********************************************************************
	// bus tasks that start and end on a falling edge
	// ********************************************************************

	task automatic start_write(input logic [31:0] addr, input logic [31:0] data);
		req.awvalid = 1'b1;
		req.awaddr  = addr;
		req.wvalid  = 1'b1;
		req.wdata   = data;
		#1;
		while (!rsp.awready) begin
			@(negedge clk);
			#1;
		end
		// data is taken in the same cycle as the address.
		compare("wready with awready", 32'd1, 32'(rsp.wready));
		// taken on the rising edge in between.
		@(negedge clk);
		req.awvalid = 1'b0;
		req.wvalid  = 1'b0;
	endtask

	task automatic finish_write(input int stall, output logic [1:0] resp);
		while (!rsp.bvalid) @(negedge clk);
		repeat (stall) begin
			#1;
			compare("write held off by pending bvalid", 32'd0, 32'(rsp.awready));
			compare("write data held off by pending bvalid", 32'd0, 32'(rsp.wready));
			@(negedge clk);
		end
		resp       = rsp.bresp;
		req.bready = 1'b1;
		@(negedge clk);
		req.bready = 1'b0;
		compare("bvalid gone after one handshake", 32'd0, 32'(rsp.bvalid));
	endtask

	task automatic start_read(input logic [31:0] addr);
		req.arvalid = 1'b1;
		req.araddr  = addr;
		#1;
		while (!rsp.arready) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		req.arvalid = 1'b0;
	endtask

	task automatic finish_read(input int stall, output logic [31:0] data,
		output logic [1:0] resp);
		while (!rsp.rvalid) @(negedge clk);
		repeat (stall) begin
			#1;
			compare("read held off by pending rvalid", 32'd0, 32'(rsp.arready));
			@(negedge clk);
		end
		data       = rsp.rdata;
		resp       = rsp.rresp;
		req.rready = 1'b1;
		@(negedge clk);
		req.rready = 1'b0;
		compare("rvalid gone after one handshake", 32'd0, 32'(rsp.rvalid));
	endtask

	task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
		input logic [1:0] exp_resp, input string name);
		logic [1:0] resp;
		start_write(addr, data);
		finish_write(0, resp);
		compare({name, " bresp"}, 32'(exp_resp), 32'(resp));
	endtask

	task automatic read_reg(input logic [31:0] addr, input logic [31:0] exp_data,
		input logic [1:0] exp_resp, input string name);
		logic [31:0] data;
		logic [1:0]  resp;
		start_read(addr);
		finish_read(0, data, resp);
		compare({name, " rdata"}, exp_data, data);
		compare({name, " rresp"}, 32'(exp_resp), 32'(resp));
	endtask

	// one full command with operands, command word, result and flags readback.
	task automatic run_op(input string name, input logic [31:0] a, input logic [31:0] b,
		input logic [31:0] cmd_word);
		last_exp = ref_model(a, b, cmd_word);
		write_reg(REG_A, a, RESP_OKAY, {name, " a"});
		write_reg(REG_B, b, RESP_OKAY, {name, " b"});
		write_reg(REG_CMD, cmd_word, RESP_OKAY, {name, " cmd"});
		read_reg(REG_RESULT, last_exp[31:0], RESP_OKAY, {name, " result"});
		read_reg(REG_FLAGS, {28'd0, last_exp[35:32]}, RESP_OKAY, {name, " flags"});
	endtask

	// ********************************************************************
	// test sequence
	// ********************************************************************

	initial begin
		logic [31:0] a_val;
		logic [31:0] b_val;
		logic [31:0] d1;
		logic [31:0] d2;
		logic [31:0] data;
		logic [1:0]  resp;
		logic [3:0]  op;
		logic        ci;
		clk       = 1'b0;
		rst_n     = 1'b0;
		req       = '0;
		lcg_state = SEED;
		last_exp  = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// reset values and operand readback.
		read_reg(REG_RESULT, 32'd0, RESP_OKAY, "reset result");
		read_reg(REG_FLAGS, 32'd0, RESP_OKAY, "reset flags");
		a_val = rand_word();
		b_val = rand_word();
		write_reg(REG_A, a_val, RESP_OKAY, "operand a");
		write_reg(REG_B, b_val, RESP_OKAY, "operand b");
		read_reg(REG_A, a_val, RESP_OKAY, "operand a readback");
		read_reg(REG_B, b_val, RESP_OKAY, "operand b readback");

		// signed overflow right at the edges.
		run_op("add overflow edge", 32'h7FFF_FFFF, 32'h1, {28'd0, OP_ADD});
		run_op("sub overflow edge", 32'h8000_0000, 32'h1, {27'd0, 1'b1, OP_SUB});
		for (int i = 0; i < 200; i++) begin
			op = 4'(rand_below(2));
			ci = 1'(rand_below(2));
			run_op($sformatf("arith %0d", i), pick_operand(), pick_operand(),
				{27'd0, ci, op});
		end
		for (int i = 0; i < 200; i++) begin
			op = 4'(2 + rand_below(3));
			run_op($sformatf("logic %0d", i), pick_operand(), pick_operand(), {28'd0, op});
		end
		for (int i = 0; i < 200; i++) begin
			op = 4'(5 + rand_below(4));
			run_op($sformatf("shift %0d", i), pick_operand(), rand_word(),
				{23'd0, 5'(rand_below(32)), op});
		end

		// rejected accesses leave result and flags alone.
		write_reg(REG_CMD, {23'd0, 5'd3, 4'(9 + rand_below(7))}, RESP_SLVERR,
			"illegal opcode");
		read_reg(REG_RESULT, last_exp[31:0], RESP_OKAY, "result after illegal opcode");
		read_reg(REG_FLAGS, {28'd0, last_exp[35:32]}, RESP_OKAY, "flags after illegal opcode");
		write_reg(REG_RESULT, 32'hDEAD_BEEF, RESP_SLVERR, "write to result");
		read_reg(REG_RESULT, last_exp[31:0], RESP_OKAY, "result after write to result");
		read_reg(32'h0000_0014, 32'd0, RESP_SLVERR, "unmapped read 0x14");
		read_reg(32'h0000_001C, 32'd0, RESP_SLVERR, "unmapped read 0x1c");

		// back-pressure with the next request already waiting.
		b_val = rand_word();
		write_reg(REG_B, b_val, RESP_OKAY, "back-pressure b");
		for (int i = 0; i < 10; i++) begin
			d1 = rand_word();
			d2 = rand_word();
			start_write(REG_A, d1);
			req.awvalid = 1'b1;
			req.awaddr  = REG_A;
			req.wvalid  = 1'b1;
			req.wdata   = d2;
			finish_write(rand_below(6), resp);
			compare("held write bresp", 32'(RESP_OKAY), 32'(resp));
			start_write(REG_A, d2);
			finish_write(rand_below(6), resp);
			compare("queued write bresp", 32'(RESP_OKAY), 32'(resp));
			start_read(REG_A);
			req.arvalid = 1'b1;
			req.araddr  = REG_B;
			finish_read(rand_below(6), data, resp);
			compare("held read of a", d2, data);
			compare("held read rresp", 32'(RESP_OKAY), 32'(resp));
			start_read(REG_B);
			finish_read(rand_below(6), data, resp);
			compare("queued read of b", b_val, data);
			compare("queued read rresp", 32'(RESP_OKAY), 32'(resp));
		end

		$display("Everything OK");
		$finish;
	end

endmodule

/* alu_unit.f */
hdl/alu_pkg.sv
hdl/alu_addsub.sv
hdl/alu_logic.sv
hdl/alu_shift.sv
hdl/alu_ctrl.sv
hdl/alu_unit.sv
dv/alu_unit_chk.sv
dv/alu_unit_tb.sv

/* Makefile */
# verilator build and run for the alu peripheral testbench.

VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = alu_unit_tb
FILELIST  = alu_unit.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulator status is ignored here, the log search decides.
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
